//--- minisrc_exec.f
+incdir+include
rtl/minisrc_pkg.sv
rtl/shift_rotate_32.sv
rtl/booth_mul_32.sv
rtl/nonrestoring_div_32.sv
rtl/alu.sv
rtl/exec_ctrl.sv
rtl/minisrc_exec.sv
test/tb_minisrc_exec.sv

//--- run_sim.sh
#!/bin/sh
# builds the minisrc_exec testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 -Mdir obj_dir --top-module tb_minisrc_exec \
	-f minisrc_exec.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_minisrc_exec > sim.log 2>&1
cat sim.log
grep -q "^>>> PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- include/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected result of one request, given the HI/LO shadow copies.
function automatic void ref_model(
	input  minisrc_pkg::alu_op_e op,
	input  logic                 inc_pc,
	input  logic                 br_flag,
	input  logic [31:0]          y,
	input  logic [31:0]          b,
	input  logic [31:0]          shadow_hi,
	input  logic [31:0]          shadow_lo,
	output logic [31:0]          exp_hi,
	output logic [31:0]          exp_lo
);
	logic [4:0]         amt;
	logic signed [63:0] prod;
	amt = b[4:0];
	exp_hi = '0;
	exp_lo = '0;
	if (inc_pc) begin
		exp_lo = b + 32'd1;
		return;
	end
	case (op)
		minisrc_pkg::op_ld, minisrc_pkg::op_ldi, minisrc_pkg::op_st,
		minisrc_pkg::op_addi, minisrc_pkg::op_add: exp_lo = y + b;
		minisrc_pkg::op_sub:  exp_lo = y - b;
		minisrc_pkg::op_and, minisrc_pkg::op_andi: exp_lo = y & b;
		minisrc_pkg::op_or, minisrc_pkg::op_ori:   exp_lo = y | b;
		minisrc_pkg::op_shr:  exp_lo = y >> amt;
		minisrc_pkg::op_shra: exp_lo = $signed(y) >>> amt;
		minisrc_pkg::op_shl:  exp_lo = y << amt;
		minisrc_pkg::op_ror:  exp_lo = y >> amt | y << (6'd32 - {1'b0, amt});
		minisrc_pkg::op_rol:  exp_lo = y << amt | y >> (6'd32 - {1'b0, amt});
		minisrc_pkg::op_neg:  exp_lo = -b;
		minisrc_pkg::op_not:  exp_lo = ~b;
		minisrc_pkg::op_branch: exp_lo = br_flag ? y + b : y;
		minisrc_pkg::op_mul: begin
			prod = $signed({{32{y[31]}}, y}) * $signed({{32{b[31]}}, b});
			exp_hi = prod[63:32];
			exp_lo = prod[31:0];
		end
		minisrc_pkg::op_div: begin
			if (b == 32'd0) begin
				exp_lo = '1;
				exp_hi = y;
			end else if (y == 32'h8000_0000 && b == 32'hffff_ffff) begin
				exp_lo = 32'h8000_0000;
				exp_hi = '0;
			end else begin
				exp_lo = $signed(y) / $signed(b);
				exp_hi = $signed(y) % $signed(b);
			end
		end
		minisrc_pkg::op_mfhi: exp_lo = shadow_hi;
		minisrc_pkg::op_mflo: exp_lo = shadow_lo;
		default: exp_lo = '0;
	endcase
endfunction

`endif

//--- test/tb_minisrc_exec.sv
`timescale 1ns/1ps

module tb_minisrc_exec;

	import minisrc_pkg::*;

	`include "tb_ref_model.svh"

	localparam int reset_cycles = 5;
	localparam int n_reqs = 2 + 200 + 5 * 32 + 16 + 4 * 24 + 20;
	localparam int timeout_cycles = n_reqs * (div_iters + 10) + reset_cycles;

	logic              clk;
	logic              arst_n;
	logic              req;
	logic              ack;
	alu_op_e           opcode;
	logic              inc_pc;
	logic              br_flag;
	logic [data_w-1:0] y;
	logic [data_w-1:0] b;
	logic [data_w-1:0] result_hi;
	logic [data_w-1:0] result_lo;

	logic [data_w-1:0] exp_hi;
	logic [data_w-1:0] exp_lo;
	logic [data_w-1:0] shadow_hi;
	logic [data_w-1:0] shadow_lo;
	int                cycles = 0;
	int                req_cycle;
	int                req_cnt;
	int                chk_cnt;
	int                err_cnt;

	alu_op_e arith_ops[12] = '{op_add, op_sub, op_and, op_or, op_ld, op_ldi, op_st,
		op_addi, op_andi, op_ori, op_neg, op_not};
	alu_op_e shift_ops[5] = '{op_shr, op_shra, op_shl, op_ror, op_rol};
	alu_op_e corner_op[8] = '{op_div, op_div, op_div, op_div, op_div, op_mul, op_mul, op_mul};
	logic [data_w-1:0] corner_y[8] = '{32'h1234_5678, 32'h8000_0000, 32'hffff_fff9, 32'd7,
		32'hffff_fff9, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
	logic [data_w-1:0] corner_b[8] = '{32'd0, 32'hffff_ffff, 32'd2, 32'hffff_fffe,
		32'hffff_fffe, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0001};

	minisrc_exec i_minisrc_exec (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.ack       (ack),
		.opcode    (opcode),
		.inc_pc    (inc_pc),
		.br_flag   (br_flag),
		.y         (y),
		.b         (b),
		.result_hi (result_hi),
		.result_lo (result_lo)
	);

	always #10 clk = ~clk;

	task automatic check_word(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %s got %h expected %h (op %s)", name, got, exp, opcode.name());
		end
	endtask

	// single-cycle operations answer on the second edge, mul and div only within a bound.
	task automatic check_op_done(input alu_op_e op, input logic ip, input int latency);
		logic multi;
		logic bad;
		multi = !ip && (op == op_mul || op == op_div);
		if (multi)
			bad = latency <= 2 || latency > div_iters + 10;
		else
			bad = latency != 2;
		chk_cnt++;
		if (bad) begin
			err_cnt++;
			$display("%s raised ack after %0d cycles, outside its allowed time", op.name(),
				latency);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		$display("test %s done, %0d errors", name, err_cnt - err_before);
	endtask

	// one four-phase handshake, holding req for extra cycles after ack.
	task automatic do_request(input alu_op_e op, input logic ip, input logic bf,
		input logic [data_w-1:0] yv, input logic [data_w-1:0] bv, input int extra);
		logic [data_w-1:0] held_hi;
		logic [data_w-1:0] held_lo;
		int n;
		ref_model(op, ip, bf, yv, bv, shadow_hi, shadow_lo, exp_hi, exp_lo);
		if (!ip && (op == op_mul || op == op_div)) begin
			shadow_hi = exp_hi;
			shadow_lo = exp_lo;
		end
		@(posedge clk);
		opcode <= op;
		inc_pc <= ip;
		br_flag <= bf;
		y <= yv;
		b <= bv;
		req <= 1'b1;
		// latency is counted in edges after the one that drives req.
		req_cycle = cycles + 1;
		req_cnt++;
		do @(negedge clk); while (!ack);
		held_hi = result_hi;
		held_lo = result_lo;
		repeat (extra) begin
			@(negedge clk);
			if (!ack) begin
				err_cnt++;
				$display("ack dropped while req was still high");
			end
			check_word("result_hi (held)", result_hi, held_hi);
			check_word("result_lo (held)", result_lo, held_lo);
		end
		@(posedge clk);
		req <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack && n < 4);
		if (ack) begin
			err_cnt++;
			$display("ack did not drop after req fell");
		end
	endtask

	// results are sampled on the falling edge after ack rises.
	always begin
		@(posedge ack);
		@(negedge clk);
		check_op_done(opcode, inc_pc, cycles - req_cycle);
		check_word("result_hi", result_hi, exp_hi);
		check_word("result_lo", result_lo, exp_lo);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, a handshake did not complete", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		int e;
		alu_op_e op;
		void'($urandom(32'hb60f_4093));
		clk = 1'b0;
		arst_n <= 1'b0;
		req <= 1'b0;
		opcode <= op_nop;
		inc_pc <= 1'b0;
		br_flag <= 1'b0;
		y <= '0;
		b <= '0;
		{req_cnt, chk_cnt, err_cnt} = '0;
		shadow_hi = '0;
		shadow_lo = '0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;

		e = err_cnt;
		@(negedge clk);
		if (ack !== 1'b0) begin
			err_cnt++;
			$display("ack is not low after reset");
		end
		check_word("result_hi", result_hi, '0);
		check_word("result_lo", result_lo, '0);
		do_request(op_mfhi, 1'b0, 1'b0, $urandom(), $urandom(), 0);
		do_request(op_mflo, 1'b0, 1'b0, $urandom(), $urandom(), 0);
		finish_test("reset", e);

		e = err_cnt;
		repeat (200)
			do_request(arith_ops[$urandom_range(0, 11)], 1'b0, 1'b0, $urandom(), $urandom(), 0);
		finish_test("arith_logic", e);

		// upper bits of b are noise that the shifter has to ignore.
		e = err_cnt;
		for (int amt = 0; amt < 32; amt++)
			for (int k = 0; k < 5; k++)
				do_request(shift_ops[k], 1'b0, 1'b0, $urandom(),
					($urandom() & 32'hffff_ffe0) | 32'(amt), 0);
		finish_test("shift_rotate", e);

		e = err_cnt;
		repeat (8)
			do_request(alu_op_e'(5'($urandom_range(0, 27))), 1'b1, 1'($urandom()),
				$urandom(), $urandom(), 0);
		repeat (8)
			do_request(op_branch, 1'b0, 1'($urandom()), $urandom(), $urandom(), 0);
		finish_test("pc_branch", e);

		e = err_cnt;
		for (int i = 0; i < 24; i++) begin
			if (i < 8)
				do_request(corner_op[i], 1'b0, 1'b0, corner_y[i], corner_b[i], 0);
			else
				do_request($urandom_range(0, 1) ? op_mul : op_div, 1'b0, 1'b0,
					$urandom(), $urandom(), 0);
			do_request(op_mfhi, 1'b0, 1'b0, $urandom(), $urandom(), 0);
			do_request(arith_ops[$urandom_range(0, 11)], 1'b0, 1'b0, $urandom(), $urandom(), 0);
			do_request(op_mflo, 1'b0, 1'b0, $urandom(), $urandom(), 0);
		end
		finish_test("mul_div", e);

		e = err_cnt;
		repeat (20) begin
			op = alu_op_e'(5'($urandom_range(0, 27)));
			do_request(op, 1'b0, 1'($urandom()), $urandom(), $urandom(), $urandom_range(0, 7));
		end
		finish_test("back_pressure", e);

		$display("%0d requests, %0d checks, %0d errors", req_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- rtl/minisrc_exec.sv
`timescale 1ns/1ps

module minisrc_exec (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            req,
	output logic                            ack,
	input  minisrc_pkg::alu_op_e            opcode,
	input  logic                            inc_pc,
	input  logic                            br_flag,
	input  logic [minisrc_pkg::data_w-1:0]  y,
	input  logic [minisrc_pkg::data_w-1:0]  b,
	output logic [minisrc_pkg::data_w-1:0]  result_hi,
	output logic [minisrc_pkg::data_w-1:0]  result_lo
);

	import minisrc_pkg::*;

	logic              start;
	logic              done;
	logic [data_w-1:0] alu_hi;
	logic [data_w-1:0] alu_lo;

	exec_ctrl i_exec_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.ack       (ack),
		.opcode    (opcode),
		.inc_pc    (inc_pc),
		.start     (start),
		.done      (done),
		.alu_hi    (alu_hi),
		.alu_lo    (alu_lo),
		.result_hi (result_hi),
		.result_lo (result_lo)
	);

	alu i_alu (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.done    (done),
		.inc_pc  (inc_pc),
		.br_flag (br_flag),
		.opcode  (opcode),
		.y       (y),
		.b       (b),
		.hi      (alu_hi),
		.lo      (alu_lo)
	);

endmodule

//--- rtl/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            req,
	output logic                            ack,
	input  minisrc_pkg::alu_op_e            opcode,
	input  logic                            inc_pc,
	output logic                            start,
	input  logic                            done,
	input  logic [minisrc_pkg::data_w-1:0]  alu_hi,
	input  logic [minisrc_pkg::data_w-1:0]  alu_lo,
	output logic [minisrc_pkg::data_w-1:0]  result_hi,
	output logic [minisrc_pkg::data_w-1:0]  result_lo
);

	import minisrc_pkg::*;

	exec_state_e state;

	// architectural HI and LO.
	logic [data_w-1:0] hi_reg;
	logic [data_w-1:0] lo_reg;
	logic              hilo_wr;
	logic              rd_hi;
	logic              rd_lo;

	assign hilo_wr = !inc_pc && (opcode == op_mul || opcode == op_div);
	assign rd_hi = !inc_pc && (opcode == op_mfhi);
	assign rd_lo = !inc_pc && (opcode == op_mflo);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			start <= 1'b0;
			ack <= 1'b0;
			hi_reg <= '0;
			lo_reg <= '0;
			result_hi <= '0;
			result_lo <= '0;
		end else begin
			case (state)
				idle: begin
					if (req) begin
						start <= 1'b1;
						state <= busy;
					end
				end
				busy: begin
					start <= 1'b0;
					if (done) begin
						ack <= 1'b1;
						state <= hold_ack;
						if (hilo_wr) begin
							hi_reg <= alu_hi;
							lo_reg <= alu_lo;
						end
						if (rd_hi) begin
							result_hi <= '0;
							result_lo <= hi_reg;
						end else if (rd_lo) begin
							result_hi <= '0;
							result_lo <= lo_reg;
						end else begin
							result_hi <= alu_hi;
							result_lo <= alu_lo;
						end
					end
				end
				hold_ack: begin
					// results stay put until the requester lets go.
					if (!req) begin
						ack <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            start,
	output logic                            done,
	input  logic                            inc_pc,
	input  logic                            br_flag,
	input  minisrc_pkg::alu_op_e            opcode,
	input  logic [minisrc_pkg::data_w-1:0]  y,
	input  logic [minisrc_pkg::data_w-1:0]  b,
	output logic [minisrc_pkg::data_w-1:0]  hi,
	output logic [minisrc_pkg::data_w-1:0]  lo
);

	import minisrc_pkg::*;

	logic [data_w-1:0] add_res;
	logic [data_w-1:0] sub_res;
	logic [data_w-1:0] shr_res;
	logic [data_w-1:0] shra_res;
	logic [data_w-1:0] shl_res;
	logic [data_w-1:0] ror_res;
	logic [data_w-1:0] rol_res;
	logic [data_w-1:0] mul_hi;
	logic [data_w-1:0] mul_lo;
	logic [data_w-1:0] div_quo;
	logic [data_w-1:0] div_rem;
	logic              is_mul;
	logic              is_div;
	logic              mul_done;
	logic              div_done;

	assign add_res = y + b;
	assign sub_res = y - b;

	// inc_pc overrides the opcode, so it also blocks the sequential units.
	assign is_mul = !inc_pc && (opcode == op_mul);
	assign is_div = !inc_pc && (opcode == op_div);

	assign done = (start && !is_mul && !is_div) || mul_done || div_done;

	shift_rotate_32 i_shift_rotate_32 (
		.value  (y),
		.amount (b[shamt_w-1:0]),
		.shr    (shr_res),
		.shra   (shra_res),
		.shl    (shl_res),
		.ror    (ror_res),
		.rol    (rol_res)
	);

	booth_mul_32 i_booth_mul_32 (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start && is_mul),
		.multiplicand (y),
		.multiplier   (b),
		.done         (mul_done),
		.hi           (mul_hi),
		.lo           (mul_lo)
	);

	nonrestoring_div_32 i_nonrestoring_div_32 (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start && is_div),
		.dividend  (y),
		.divisor   (b),
		.done      (div_done),
		.quotient  (div_quo),
		.remainder (div_rem)
	);

	always_comb begin
		hi = '0;
		lo = '0;
		if (inc_pc) begin
			lo = b + 32'd1;
		end else begin
			case (opcode)
				op_ld, op_ldi, op_st, op_addi, op_add: lo = add_res;
				op_sub:          lo = sub_res;
				op_and, op_andi: lo = y & b;
				op_or, op_ori:   lo = y | b;
				op_shr:          lo = shr_res;
				op_shra:         lo = shra_res;
				op_shl:          lo = shl_res;
				op_ror:          lo = ror_res;
				op_rol:          lo = rol_res;
				op_neg:          lo = -b;
				op_not:          lo = ~b;
				op_branch:       lo = br_flag ? add_res : y;
				op_mul: begin
					hi = mul_hi;
					lo = mul_lo;
				end
				op_div: begin
					hi = div_rem;
					lo = div_quo;
				end
				default: lo = '0;
			endcase
		end
	end

endmodule

//--- rtl/nonrestoring_div_32.sv
`timescale 1ns/1ps

module nonrestoring_div_32 (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            start,
	input  logic [minisrc_pkg::data_w-1:0]  dividend,
	input  logic [minisrc_pkg::data_w-1:0]  divisor,
	output logic                            done,
	output logic [minisrc_pkg::data_w-1:0]  quotient,
	output logic [minisrc_pkg::data_w-1:0]  remainder
);

	import minisrc_pkg::*;

	seq_state_e state;
	logic [div_cnt_w-1:0] count;

	// partial remainder carries one extra sign bit.
	logic [data_w:0]   rem_q;
	logic [data_w-1:0] quo_q;
	logic [data_w-1:0] dsr_q;
	logic [data_w-1:0] dvd_q;
	logic              neg_quo;
	logic              neg_rem;
	logic              div_zero;

	logic [data_w-1:0] dvd_mag;
	logic [data_w-1:0] dsr_mag;
	logic [data_w:0]   shifted;
	logic [data_w:0]   rem_next;
	logic [data_w:0]   rem_fix;

	assign dvd_mag = dividend[data_w-1] ? -dividend : dividend;
	assign dsr_mag = divisor[data_w-1] ? -divisor : divisor;

	// subtract while the partial remainder is positive, add back otherwise.
	assign shifted = {rem_q[data_w-1:0], quo_q[data_w-1]};
	assign rem_next = rem_q[data_w] ? shifted + {1'b0, dsr_q} : shifted - {1'b0, dsr_q};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_idle;
			count <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						count <= '0;
						state <= s_run;
					end
				end
				s_run: begin
					count <= count + 1'b1;
					if (count == div_cnt_w'(div_iters - 1))
						state <= s_done;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_idle && start) begin
			rem_q <= '0;
			quo_q <= dvd_mag;
			dsr_q <= dsr_mag;
			dvd_q <= dividend;
			neg_quo <= dividend[data_w-1] ^ divisor[data_w-1];
			neg_rem <= dividend[data_w-1];
			div_zero <= (divisor == '0);
		end else if (state == s_run) begin
			rem_q <= rem_next;
			quo_q <= {quo_q[data_w-2:0], ~rem_next[data_w]};
		end
	end

	// final correction of a negative remainder, then the signs.
	assign rem_fix = rem_q[data_w] ? rem_q + {1'b0, dsr_q} : rem_q;

	always_comb begin
		if (div_zero) begin
			quotient = '1;
			remainder = dvd_q;
		end else begin
			quotient = neg_quo ? -quo_q : quo_q;
			remainder = neg_rem ? -rem_fix[data_w-1:0] : rem_fix[data_w-1:0];
		end
	end

	assign done = (state == s_done);

endmodule

//--- rtl/booth_mul_32.sv
`timescale 1ns/1ps

module booth_mul_32 (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            start,
	input  logic [minisrc_pkg::data_w-1:0]  multiplicand,
	input  logic [minisrc_pkg::data_w-1:0]  multiplier,
	output logic                            done,
	output logic [minisrc_pkg::data_w-1:0]  hi,
	output logic [minisrc_pkg::data_w-1:0]  lo
);

	import minisrc_pkg::*;

	seq_state_e state;
	logic [mul_cnt_w-1:0] count;

	// product layout is {acc (data_w+2), multiplier (data_w), guard bit}.
	logic [2*data_w+2:0] prod;
	logic [data_w+1:0] mcand;
	logic [data_w+1:0] mcand_ext;

	function automatic logic [2*data_w+2:0] booth_step(
		input logic [2*data_w+2:0] p,
		input logic [data_w+1:0]   m
	);
		logic [data_w+1:0] acc;
		logic [2*data_w+2:0] sum;
		case (p[2:0])
			3'b001, 3'b010: acc = p[2*data_w+2:data_w+1] + m;
			3'b011:         acc = p[2*data_w+2:data_w+1] + (m << 1);
			3'b100:         acc = p[2*data_w+2:data_w+1] - (m << 1);
			3'b101, 3'b110: acc = p[2*data_w+2:data_w+1] - m;
			default:        acc = p[2*data_w+2:data_w+1];
		endcase
		sum = {acc, p[data_w:0]};
		// arithmetic shift right by two.
		return {{2{sum[2*data_w+2]}}, sum[2*data_w+2:2]};
	endfunction

	assign mcand_ext = {{2{multiplicand[data_w-1]}}, multiplicand};

	// the loading edge already retires the first digit.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_idle;
			count <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						count <= mul_cnt_w'(1);
						state <= s_run;
					end
				end
				s_run: begin
					count <= count + 1'b1;
					if (count == mul_cnt_w'(mul_iters - 1))
						state <= s_done;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_idle && start) begin
			mcand <= mcand_ext;
			prod <= booth_step({{(data_w+2){1'b0}}, multiplier, 1'b0}, mcand_ext);
		end else if (state == s_run) begin
			prod <= booth_step(prod, mcand);
		end
	end

	assign done = (state == s_done);
	assign hi = prod[2*data_w:data_w+1];
	assign lo = prod[data_w:1];

endmodule

//--- rtl/shift_rotate_32.sv
`timescale 1ns/1ps

module shift_rotate_32 (
	input  logic [minisrc_pkg::data_w-1:0]  value,
	input  logic [minisrc_pkg::shamt_w-1:0] amount,
	output logic [minisrc_pkg::data_w-1:0]  shr,
	output logic [minisrc_pkg::data_w-1:0]  shra,
	output logic [minisrc_pkg::data_w-1:0]  shl,
	output logic [minisrc_pkg::data_w-1:0]  ror,
	output logic [minisrc_pkg::data_w-1:0]  rol
);

	import minisrc_pkg::*;

	logic [2*data_w-1:0] doubled;
	logic [2*data_w-1:0] ror_wide;
	logic [2*data_w-1:0] rol_wide;

	assign shr = value >> amount;
	assign shl = value << amount;

	// sign bit refills from the left.
	assign shra = $signed(value) >>> amount;

	// rotates come from a doubled copy so an amount of zero needs no special case.
	assign doubled = {value, value};
	assign ror_wide = doubled >> amount;
	assign rol_wide = doubled << amount;

	assign ror = ror_wide[data_w-1:0];
	assign rol = rol_wide[2*data_w-1:data_w];

endmodule

//--- rtl/minisrc_pkg.sv
package minisrc_pkg;

	localparam int data_w = 32;
	localparam int shamt_w = 5;

	// iteration counts of the sequential units.
	localparam int mul_iters = 16;
	localparam int div_iters = 32;
	localparam int mul_cnt_w = 4;
	localparam int div_cnt_w = 5;

	// encodings follow the instruction set opcode field.
	typedef enum logic [4:0] {
		op_ld = 5'd0,
		op_ldi,
		op_st,
		op_add,
		op_sub,
		op_and,
		op_or,
		op_shr,
		op_shra,
		op_shl,
		op_ror,
		op_rol,
		op_addi,
		op_andi,
		op_ori,
		op_mul,
		op_div,
		op_neg,
		op_not,
		op_branch,
		op_jr,
		op_jal,
		op_in,
		op_out,
		op_mfhi,
		op_mflo,
		op_nop,
		op_halt = 5'd27
	} alu_op_e;

	typedef enum logic [1:0] {idle, busy, hold_ack} exec_state_e;

	typedef enum logic [1:0] {s_idle, s_run, s_done} seq_state_e;

endpackage
